// ==== ks_multiplier.f ====
mult_pkg.sv
mult_if.sv
prefix_adder.sv
pp_generator.sv
pp_pair_adder.sv
product_reducer.sv
ks_multiplier.sv
mult_checker.sv
mult_monitor.sv
tb_ks_multiplier.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ks_multiplier
FILELIST  ?= ks_multiplier.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_ks_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ks_multiplier;
  import mult_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int N_CORNER    = 16;
  localparam int N_RAND      = 200;
  localparam int N_TOTAL     = N_CORNER + N_RAND;
  localparam int NAME_W      = 8 * 16;
  localparam int DRAIN_LIMIT = 8; // three-cycle latency plus margin

  logic              clk = 1'b0;
  logic              arst_n;
  logic              in_valid;
  operand_t          a;
  operand_t          b;
  logic              out_valid;
  product_t          product;
  logic [NAME_W-1:0] cur_name;
  int                pending;
  int                errors;
  int                drain_cycles;

  logic [NAME_W-1:0] name_tbl  [N_TOTAL];
  operand_t          a_tbl     [N_TOTAL];
  operand_t          b_tbl     [N_TOTAL];
  logic              valid_tbl [N_TOTAL];
  int                fill_idx = 0;
  logic [31:0]       seed;
  operand_t          rand_a;

  always #(CLK_PERIOD / 2) clk = ~clk;

  ks_multiplier uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
  );

  mult_monitor #(
    .NAME_W (NAME_W)
  ) u_mon (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .a            (a),
    .b            (b),
    .name         (cur_name),
    .out_valid    (out_valid),
    .product      (product),
    .assert_fails (uut.u_chk.fail_count),
    .pending      (pending)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_entry(input logic [NAME_W-1:0] name, input operand_t x,
                           input operand_t y, input logic valid);
    name_tbl[fill_idx]  = name;
    a_tbl[fill_idx]     = x;
    b_tbl[fill_idx]     = y;
    valid_tbl[fill_idx] = valid;
    fill_idx++;
  endtask

  initial begin
    arst_n   = 1'b0;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    cur_name = '0;
    add_entry("zero_zero", 8'h00, 8'h00, 1'b1);
    add_entry("zero_max", 8'h00, 8'hff, 1'b1);
    add_entry("max_zero", 8'hff, 8'h00, 1'b1);
    add_entry("max_max", 8'hff, 8'hff, 1'b1); // 65025 carries through every level
    add_entry("one_x_a5", 8'h01, 8'ha5, 1'b1);
    add_entry("one_x_max", 8'h01, 8'hff, 1'b1);
    add_entry("pow2_2x64", 8'h02, 8'h40, 1'b1);
    add_entry("pow2_8x16", 8'h08, 8'h10, 1'b1);
    add_entry("pow2_128x128", 8'h80, 8'h80, 1'b1);
    add_entry("pow2_4x32", 8'h04, 8'h20, 1'b1);
    add_entry("idle_gap", 8'h3c, 8'hc3, 1'b0);
    add_entry("idle_gap", 8'h00, 8'hff, 1'b0);
    add_entry("alt_aa_x_55", 8'haa, 8'h55, 1'b1);
    add_entry("alt_55_x_aa", 8'h55, 8'haa, 1'b1);
    add_entry("alt_aa_x_aa", 8'haa, 8'haa, 1'b1);
    add_entry("alt_55_x_55", 8'h55, 8'h55, 1'b1);
    seed = 32'hd5e42025;
    for (int r = 0; r < N_RAND; r++) begin
      seed   = lcg_next(seed);
      rand_a = seed[31:24]; // upper bits are the better ones
      seed   = lcg_next(seed);
      add_entry("random", rand_a, seed[31:24], 1'b1);
    end
    repeat (2) @(posedge clk);
    #2 arst_n = 1'b1;
    repeat (3) @(posedge clk); // out_valid has to stay low while idle
    for (int i = 0; i < N_TOTAL; i++) begin
      @(posedge clk);
      #2;
      in_valid = valid_tbl[i];
      a        = a_tbl[i];
      b        = b_tbl[i];
      cur_name = name_tbl[i];
    end
    @(posedge clk);
    #2 in_valid = 1'b0;
    drain_cycles = 0;
    while (pending != 0 && drain_cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      #2;
      drain_cycles++;
    end
    u_mon.report_counts(errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #((N_TOTAL + 20) * CLK_PERIOD);
    $display("timeout, results still missing after %0d cycles", N_TOTAL + 20);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mult_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_monitor #(
  parameter int NAME_W = 128
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid,
  input  mult_pkg::operand_t a,
  input  mult_pkg::operand_t b,
  input  logic [NAME_W-1:0]  name,
  input  logic               out_valid,
  input  mult_pkg::product_t product,
  input  int                 assert_fails,
  output int                 pending
);
  import mult_pkg::*;

  logic [NAME_W-1:0] name_q [$];
  product_t          exp_q  [$];
  int                mismatches = 0;
  int                unexpected = 0;
  int                leftover   = 0;

  initial pending = 0;

  always @(posedge clk) begin
    if (arst_n) begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("out_valid went high at %0t with no operation in flight", $time);
          unexpected++;
        end else begin
          if (product !== exp_q[0]) begin
            $display("ERROR %0s expected %0d actual %0d", name_q[0], exp_q[0], product);
            mismatches++;
          end
          void'(name_q.pop_front());
          void'(exp_q.pop_front());
        end
      end
      if (in_valid) begin
        name_q.push_back(name);
        exp_q.push_back(product_t'(a) * product_t'(b)); // full width, no wrap
      end
      pending = exp_q.size();
    end
  end

  task automatic report_counts(output int total);
    leftover = exp_q.size();
    if (leftover != 0) begin
      $display("%0d operations never came out of the pipeline", leftover);
    end
    total = mismatches + unexpected + leftover + assert_fails;
    $display("mismatches %0d, unexpected outputs %0d, missing outputs %0d, assertion fails %0d",
             mismatches, unexpected, leftover, assert_fails);
  endtask

endmodule

`default_nettype wire

// ==== mult_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_checker (
  input logic                            clk,
  input logic                            arst_n,
  input logic                            in_valid,
  input logic                            out_valid,
  input logic [mult_pkg::PAIR_LANES-1:0] lane_valid
);

  int fail_count = 0; // read by the testbench monitor

  a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
      $error("out_valid high while arst_n is low");
      fail_count++;
    end

  // fixed three-stage latency
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == $past(in_valid, 3))
    else begin
      $error("out_valid does not follow in_valid by three cycles");
      fail_count++;
    end

  a_lanes_lockstep: assert property (@(posedge clk) disable iff (!arst_n)
    (&lane_valid) || !(|lane_valid))
    else begin
      $error("pair lane valids disagree");
      fail_count++;
    end

endmodule

bind ks_multiplier mult_checker u_chk (
  .clk        (clk),
  .arst_n     (arst_n),
  .in_valid   (in_valid),
  .out_valid  (out_valid),
  .lane_valid (pair_if.valid)
);

`default_nettype wire

// ==== ks_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module ks_multiplier (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           in_valid,
  input  logic [mult_pkg::OPERAND_W-1:0] a,
  input  logic [mult_pkg::OPERAND_W-1:0] b,
  output logic                           out_valid,
  output logic [mult_pkg::PRODUCT_W-1:0] product
);
  import mult_pkg::*;

  pp_bus   pp_if ();   // stage 1 out
  pair_bus pair_if (); // stage 2 out

  pp_generator u_pp_gen (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .pp       (pp_if.src)
  );

  // one adder per pair of rows
  for (genvar i = 0; i < PAIR_LANES; i++) begin : g_lane
    pp_pair_adder #(
      .LANE (i)
    ) u_pair (
      .clk    (clk),
      .arst_n (arst_n),
      .pp     (pp_if.dst),
      .pair   (pair_if.src)
    );
  end

  product_reducer u_reduce (
    .clk       (clk),
    .arst_n    (arst_n),
    .pair      (pair_if.dst),
    .product   (product),
    .out_valid (out_valid)
  );

endmodule

`default_nettype wire

// ==== product_reducer.sv ====
`timescale 1ns/1ps
`default_nettype none

module product_reducer (
  input  logic               clk,
  input  logic               arst_n,
  pair_bus.dst               pair,
  output mult_pkg::product_t product,
  output logic               out_valid
);
  import mult_pkg::*;

  // pair sums 0+1 and 2+3, each at most 5 * 765
  logic [PAIR_W+1:0] lo_a;
  logic [PAIR_W+1:0] lo_b;
  logic [PAIR_W+1:0] lo_sum;
  logic [PAIR_W+1:0] hi_a;
  logic [PAIR_W+1:0] hi_b;
  logic [PAIR_W+1:0] hi_sum;
  product_t          fin_a;
  product_t          fin_b;
  product_t          fin_sum;

  assign lo_a = {2'b00, pair.sum[0]};
  assign lo_b = {pair.sum[1], 2'b00}; // lane 1 sits two rows up
  assign hi_a = {2'b00, pair.sum[2]};
  assign hi_b = {pair.sum[3], 2'b00};

  prefix_adder #(
    .WIDTH (PAIR_W + 2)
  ) u_add_lo (
    .a    (lo_a),
    .b    (lo_b),
    .sum  (lo_sum),
    .cout ()
  );

  prefix_adder #(
    .WIDTH (PAIR_W + 2)
  ) u_add_hi (
    .a    (hi_a),
    .b    (hi_b),
    .sum  (hi_sum),
    .cout ()
  );

  // upper half starts four rows up
  assign fin_a = {{(PRODUCT_W-PAIR_W-2){1'b0}}, lo_sum};
  assign fin_b = {hi_sum, 4'b0000};

  prefix_adder #(
    .WIDTH (PRODUCT_W)
  ) u_add_fin (
    .a    (fin_a),
    .b    (fin_b),
    .sum  (fin_sum),
    .cout ()
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pair.valid[0]; // lanes are in lockstep
    end
  end

  always_ff @(posedge clk) begin
    if (pair.valid[0]) begin
      product <= fin_sum;
    end
  end

endmodule

`default_nettype wire

// ==== pp_pair_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module pp_pair_adder #(
  parameter int LANE = 0
) (
  input logic  clk,
  input logic  arst_n,
  pp_bus.dst   pp,
  pair_bus.src pair
);
  import mult_pkg::*;

  logic [OPERAND_W:0] add_a;    // even row
  logic [OPERAND_W:0] add_b;    // odd row, one weight up
  logic [OPERAND_W:0] add_sum;
  logic               add_cout;
  pair_sum_t          sum_q;
  logic               valid_q;

  assign add_a = {1'b0, pp.row[2*LANE]};
  assign add_b = {pp.row[2*LANE+1], 1'b0};

  prefix_adder #(
    .WIDTH (OPERAND_W + 1)
  ) u_add (
    .a    (add_a),
    .b    (add_b),
    .sum  (add_sum),
    .cout (add_cout)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pp.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pp.valid) begin
      sum_q <= {add_cout, add_sum}; // carry is the top bit of the pair
    end
  end

  // each lane owns one entry of the bus
  assign pair.sum[LANE]   = sum_q;
  assign pair.valid[LANE] = valid_q;

endmodule

`default_nettype wire

// ==== pp_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module pp_generator (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid,
  input  mult_pkg::operand_t a,
  input  mult_pkg::operand_t b,
  pp_bus.src                 pp
);
  import mult_pkg::*;

  pp_row_t row_d [PP_ROWS];

  // and array
  always_comb begin
    for (int k = 0; k < PP_ROWS; k++) begin
      row_d[k] = a[k] ? b : '0; // b gated by bit k of a
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pp.valid <= 1'b0;
    end else begin
      pp.valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      for (int k = 0; k < PP_ROWS; k++) begin
        pp.row[k] <= row_d[k];
      end
    end
  end

endmodule

`default_nettype wire

// ==== prefix_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefix_adder #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] sum,
  output logic             cout
);

  // level 0 holds the per-bit terms, the last level the full prefixes
  logic [WIDTH-1:0] g_lvl [0:$clog2(WIDTH)];
  logic [WIDTH-1:0] p_lvl [0:$clog2(WIDTH)];
  logic [WIDTH-1:0] carry;

  assign g_lvl[0] = a & b;
  assign p_lvl[0] = a ^ b;

  for (genvar lvl = 0; lvl < $clog2(WIDTH); lvl++) begin : g_level
    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
      if (i >= (2 << lvl)) begin : g_black
        // group still open at bit 0 side, keep both terms
        assign g_lvl[lvl+1][i] = g_lvl[lvl][i] |
                                 (p_lvl[lvl][i] & g_lvl[lvl][i-(1<<lvl)]);
        assign p_lvl[lvl+1][i] = p_lvl[lvl][i] & p_lvl[lvl][i-(1<<lvl)];
      end else if (i >= (1 << lvl)) begin : g_gray
        assign g_lvl[lvl+1][i] = g_lvl[lvl][i] |
                                 (p_lvl[lvl][i] & g_lvl[lvl][i-(1<<lvl)]);
        assign p_lvl[lvl+1][i] = 1'b0; // span reaches bit 0, no carry-in
      end else begin : g_buf
        assign g_lvl[lvl+1][i] = g_lvl[lvl][i]; // prefix already complete
        assign p_lvl[lvl+1][i] = p_lvl[lvl][i];
      end
    end
  end

  // carry into bit i is the prefix generate of bits i-1 down to 0
  assign carry = {g_lvl[$clog2(WIDTH)][WIDTH-2:0], 1'b0};
  assign sum   = p_lvl[0] ^ carry;
  assign cout  = g_lvl[$clog2(WIDTH)][WIDTH-1];

endmodule

`default_nettype wire

// ==== mult_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 1 to stage 2, all partial-product rows of one operand pair
interface pp_bus;
  import mult_pkg::*;

  logic    valid;
  pp_row_t row [PP_ROWS]; // row k has weight 2**k

  modport src (
    output valid,
    output row
  );

  modport dst (
    input valid,
    input row
  );

endinterface

// stage 2 to stage 3, one pair sum per lane
interface pair_bus;
  import mult_pkg::*;

  logic [PAIR_LANES-1:0] valid;           // one per lane, all move together
  pair_sum_t             sum [PAIR_LANES]; // lane i has weight 4**i

  modport src (
    output valid,
    output sum
  );

  modport dst (
    input valid,
    input sum
  );

endinterface

`default_nettype wire

// ==== mult_pkg.sv ====
`default_nettype none

package mult_pkg;

  // operand and result widths
  localparam int OPERAND_W = 8;
  localparam int PRODUCT_W = 2 * OPERAND_W;

  // one row per multiplier bit
  localparam int PP_ROWS = OPERAND_W;

  // rows are summed two at a time
  localparam int PAIR_LANES = PP_ROWS / 2;

  // row + (row << 1) needs two extra bits
  localparam int PAIR_W = OPERAND_W + 2;

  typedef logic [OPERAND_W-1:0] operand_t;  // one factor
  typedef logic [OPERAND_W-1:0] pp_row_t;   // multiplicand gated by one bit
  typedef logic [PAIR_W-1:0]    pair_sum_t; // sum of two adjacent rows
  typedef logic [PRODUCT_W-1:0] product_t;  // full product

endpackage

`default_nettype wire
